/* src.f */
+incdir+test
logic/rv_core_pkg.sv
logic/muldiv_pkg.sv
logic/muldiv_dispatch.sv
logic/multiplier.sv
logic/divider.sv
logic/muldiv_unit.sv
test/tb_muldiv.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_muldiv
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# pass only if the simulation output holds the pass message
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/muldiv_model.svh */
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// expected RV32M result, worked out in 64-bit arithmetic
function automatic word_t expected_result(input md_op_e op, input word_t a, input word_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        prod;
    word_t              res;

    sa   = {{32{a[31]}}, a};
    sb   = {{32{b[31]}}, b};
    ua   = {32'h0, a};
    ub   = {32'h0, b};
    prod = '0;
    res  = '0;
    case (op)
        MD_MUL: begin
            prod = ua * ub;
            res  = prod[31:0];
        end
        MD_MULH: begin
            prod = sa * sb;
            res  = prod[63:32];
        end
        MD_MULHSU: begin
            prod = sa * $signed(ub); // ub is zero extended, stays positive
            res  = prod[63:32];
        end
        MD_MULHU: begin
            prod = ua * ub;
            res  = prod[63:32];
        end
        // most negative / -1 is 2^31 here, which truncates back to itself
        MD_DIV:  res = (b == '0) ? 32'hffff_ffff : 32'(sa / sb);
        MD_DIVU: res = (b == '0) ? 32'hffff_ffff : 32'(ua / ub);
        MD_REM:  res = (b == '0) ? a : 32'(sa % sb); // sign follows dividend
        MD_REMU: res = (b == '0) ? a : 32'(ua % ub);
        default: res = 'x;
    endcase
    return res;
endfunction

`endif

/* test/tb_muldiv.sv */
`timescale 1ns/1ps

module tb_muldiv;
    import rv_core_pkg::*;
    import muldiv_pkg::*;

    `include "muldiv_model.svh"

    localparam int STEP_BITS    = 2;
    localparam int MUL_LAT      = 2 + XLEN / STEP_BITS;
    localparam int DIV_LAT      = 35;
    localparam int DIV_ZERO_LAT = 2;
    localparam int WAIT_LIMIT   = 100; // cycles per wait

    logic    clk;
    logic    rst_n;
    md_req_t req_i;
    logic    start_i;
    logic    ready_i;
    logic    busy_o;
    md_rsp_t rsp_o;

    integer  seed;
    logic    accepted;
    logic    in_flight;  // an accepted operation has not returned yet
    int      cyc_cnt;    // edges since the accepting edge
    int      exp_lat;
    word_t   exp_result;
    logic    rsp_valid;
    word_t   rsp_result;
    word_t   corners [5];

    muldiv_unit #(
        .MUL_STEP_BITS (STEP_BITS)
    ) dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (req_i),
        .start_i (start_i),
        .ready_i (ready_i),
        .busy_o  (busy_o),
        .rsp_o   (rsp_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int expected_latency(input md_op_e op, input word_t divisor);
        if (op inside {MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU}) begin
            return MUL_LAT;
        end
        return (divisor == '0) ? DIV_ZERO_LAT : DIV_LAT;
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        $display("** Error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic show_failure(input string what);
        $display("** Error at %0d ns: %s", $time, what);
        abort_run();
    endtask

    assign accepted   = start_i && ready_i && !busy_o;
    assign rsp_valid  = rsp_o.valid;
    assign rsp_result = rsp_o.result;

    // expected result and latency latched at each accepted start
    always @(posedge clk) begin
        if (!rst_n) begin
            in_flight  <= 1'b0;
            cyc_cnt    <= 0;
            exp_lat    <= 0;
            exp_result <= '0;
        end else if (accepted) begin
            in_flight  <= 1'b1;
            cyc_cnt    <= 0;
            exp_lat    <= expected_latency(req_i.op, req_i.rs2);
            exp_result <= expected_result(req_i.op, req_i.rs1, req_i.rs2);
        end else if (in_flight) begin
            cyc_cnt <= cyc_cnt + 1;
            if (rsp_valid) begin
                in_flight <= 1'b0;
            end
        end
    end

    reset_check: assert property (@(posedge clk)
        $rose(rst_n) |-> ({busy_o, rsp_o} == '0))
        else show_mismatch("{busy_o, rsp_o}", 64'(0), 64'($sampled({busy_o, rsp_o})));

    result_check: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp_valid) |-> (rsp_result == exp_result))
        else show_mismatch("rsp_o.result", 64'(exp_result), 64'($sampled(rsp_result)));

    latency_check: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp_valid) |-> (cyc_cnt == exp_lat))
        else show_mismatch("rsp_o.valid latency", 64'(exp_lat), 64'($sampled(cyc_cnt)));

    spurious_check: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp_valid) |-> in_flight)
        else show_failure("rsp_o.valid rose with no operation in flight");

    // result held while the stage stalls
    hold_check: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid && !ready_i) |=> (rsp_valid && $stable(rsp_result)))
        else show_failure("rsp_o.valid dropped or rsp_o.result changed with ready_i low");

    ignore_check: assert property (@(posedge clk) disable iff (!rst_n)
        (start_i && !ready_i && !busy_o && !rsp_valid) |=> (!busy_o && !rsp_valid))
        else show_failure("start_i with ready_i low was accepted");

    busy_check: assert property (@(posedge clk) disable iff (!rst_n)
        (in_flight && !rsp_valid) |-> busy_o)
        else show_mismatch("busy_o", 64'(1), 64'($sampled(busy_o)));

    idle_check: assert property (@(posedge clk) disable iff (!rst_n)
        (!in_flight || rsp_valid) |-> !busy_o)
        else show_mismatch("busy_o", 64'(0), 64'($sampled(busy_o)));

    task automatic wait_for_valid();
        int n;
        n = 0;
        while (!rsp_valid) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                show_failure("timeout waiting for rsp_o.valid");
            end
        end
    endtask

    // one operation with ready_i low for hold cycles once the result is there
    task automatic issue_op(input md_op_e op, input word_t a, input word_t b, input int hold);
        @(negedge clk);
        req_i.op  = op;
        req_i.rs1 = a;
        req_i.rs2 = b;
        start_i   = 1'b1;
        ready_i   = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        if (hold > 0) begin
            ready_i = 1'b0;
        end
        wait_for_valid();
        repeat (hold) @(negedge clk);
        ready_i = 1'b1;
        @(negedge clk);
    endtask

    task automatic ignored_start(input md_op_e op, input word_t a, input word_t b);
        @(negedge clk);
        req_i.op  = op;
        req_i.rs1 = a;
        req_i.rs2 = b;
        ready_i   = 1'b0;
        start_i   = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        repeat (4) @(negedge clk);
        ready_i = 1'b1;
    endtask

    initial begin
        word_t  a;
        word_t  b;
        md_op_e op;

        seed    = 32'h3d0a02c5;
        rst_n   = 1'b0;
        start_i = 1'b0;
        ready_i = 1'b1;
        req_i   = '0;
        corners = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int k = 0; k < 8; k++) begin
            op = md_op_e'(k[2:0]);
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    issue_op(op, corners[i], corners[j], 0);
                end
            end
            repeat (6) begin
                a = $random(seed);
                b = $random(seed);
                issue_op(op, a, b, 0);
                issue_op(op, a, b & 32'h0000_00ff, 0); // small divisors too
            end
            a = $random(seed);
            issue_op(op, a, '0, 0);
        end

        // stalled execute stage
        issue_op(MD_MULH, 32'h8000_0000, 32'h7fff_ffff, 3);
        issue_op(MD_DIV, 32'hffff_ff85, 32'h0000_0007, 5);
        issue_op(MD_REMU, 32'h1234_5678, '0, 2);

        ignored_start(MD_DIV, 32'd100, 32'd7);
        ignored_start(MD_MUL, 32'd3, 32'd5);
        issue_op(MD_MUL, 32'd3, 32'd5, 0);

        $display("Testbench passed");
        $finish;
    end

endmodule

/* logic/muldiv_unit.sv */
`timescale 1ns/1ps

// RV32M multiply/divide unit of the execute stage
module muldiv_unit #(
    parameter int MUL_STEP_BITS = 2 // 1, 2 or 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  muldiv_pkg::md_req_t req_i,
    input  logic                start_i,
    input  logic                ready_i,
    output logic                busy_o,
    output muldiv_pkg::md_rsp_t rsp_o
);
    import muldiv_pkg::*;

    eng_req_t eng_req;
    logic     mul_start;
    logic     div_start;
    mul_op_e  mul_op;
    div_op_e  div_op;
    logic     mul_busy;
    logic     div_busy;
    md_rsp_t  mul_rsp;
    md_rsp_t  div_rsp;

    muldiv_dispatch disp0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .start_i     (start_i),
        .mul_busy_i  (mul_busy),
        .div_busy_i  (div_busy),
        .mul_rsp_i   (mul_rsp),
        .div_rsp_i   (div_rsp),
        .eng_req_o   (eng_req),
        .mul_start_o (mul_start),
        .mul_op_o    (mul_op),
        .div_start_o (div_start),
        .div_op_o    (div_op),
        .busy_o      (busy_o),
        .rsp_o       (rsp_o)
    );

    multiplier #(
        .MUL_STEP_BITS (MUL_STEP_BITS)
    ) mul0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (mul_start),
        .ready_i (ready_i),
        .op_i    (mul_op),
        .req_i   (eng_req),
        .busy_o  (mul_busy),
        .rsp_o   (mul_rsp)
    );

    divider div0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (div_start),
        .ready_i (ready_i),
        .op_i    (div_op),
        .req_i   (eng_req),
        .busy_o  (div_busy),
        .rsp_o   (div_rsp)
    );

endmodule

/* logic/divider.sv */
`timescale 1ns/1ps

// restoring divider, one quotient bit per CALC cycle
module divider (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  logic                 ready_i,
    input  muldiv_pkg::div_op_e  op_i,
    input  muldiv_pkg::eng_req_t req_i,
    output logic                 busy_o,
    output muldiv_pkg::md_rsp_t  rsp_o
);
    import rv_core_pkg::*;
    import muldiv_pkg::*;

    localparam int CNT_W = $clog2(XLEN + 1);

    typedef enum logic [1:0] {
        IDLE,
        START,
        CALC,
        END
    } state_e;

    state_e           state_q;
    div_op_e          op_q;
    logic [CNT_W-1:0] cnt_q;
    logic             neg_q; // negate the selected result
    word_t            a_q;
    word_t            b_q;
    word_t            dvs_q; // divisor magnitude
    logic [XLEN:0]    dq_q;  // dividend bits out at the top, quotient bits in at the bottom
    word_t            rem_q; // partial remainder

    logic             div_zero;
    logic             a_neg;
    logic             b_neg;
    word_t            a_mag;
    word_t            b_mag;
    logic [XLEN:0]    shifted;
    logic [XLEN:0]    diff;
    logic             sub_ok;
    word_t            res_sel;

    assign div_zero = (b_q == '0);

    // only DIV and REM treat the operands as signed
    assign a_neg = (op_q == DIV_S || op_q == REM_S) && a_q[XLEN-1];
    assign b_neg = (op_q == DIV_S || op_q == REM_S) && b_q[XLEN-1];
    assign a_mag = a_neg ? -a_q : a_q;
    assign b_mag = b_neg ? -b_q : b_q;

    // trial subtraction
    assign shifted = {rem_q, dq_q[XLEN]};
    assign diff    = shifted - {1'b0, dvs_q};
    assign sub_ok  = (shifted >= {1'b0, dvs_q});

    assign res_sel = (op_q == DIV_S || op_q == DIV_U) ? dq_q[XLEN-1:0] : rem_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            op_q    <= DIV_S;
            cnt_q   <= '0;
            neg_q   <= 1'b0;
            busy_o  <= 1'b0;
            rsp_o   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (ready_i) begin
                        rsp_o.valid <= 1'b0;
                        if (start_i) begin
                            op_q    <= op_i;
                            busy_o  <= 1'b1;
                            state_q <= START;
                        end else begin
                            rsp_o.result <= '0;
                        end
                    end
                end
                START: begin
                    if (div_zero) begin
                        neg_q   <= 1'b0; // RISC-V result used as is
                        state_q <= END;
                    end else begin
                        // quotient sign from both operands, remainder follows the dividend
                        if (op_q == DIV_S) begin
                            neg_q <= a_q[XLEN-1] ^ b_q[XLEN-1];
                        end else begin
                            neg_q <= (op_q == REM_S) && a_q[XLEN-1];
                        end
                        cnt_q   <= CNT_W'(XLEN); // XLEN + 1 steps, zero bit first
                        state_q <= CALC;
                    end
                end
                CALC: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == '0) begin
                        state_q <= END;
                    end
                end
                END: begin
                    state_q      <= IDLE;
                    busy_o       <= 1'b0;
                    rsp_o.valid  <= 1'b1;
                    rsp_o.result <= neg_q ? -res_sel : res_sel;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // operand, quotient and remainder datapath
    always_ff @(posedge clk) begin
        case (state_q)
            IDLE: begin
                if (ready_i && start_i) begin
                    a_q <= req_i.a;
                    b_q <= req_i.b;
                end
            end
            START: begin
                dvs_q <= b_mag;
                if (div_zero) begin
                    dq_q  <= {1'b0, {XLEN{1'b1}}}; // quotient all ones
                    rem_q <= a_q;                  // remainder is the dividend
                end else begin
                    dq_q  <= {1'b0, a_mag};
                    rem_q <= '0;
                end
            end
            CALC: begin
                dq_q  <= {dq_q[XLEN-1:0], sub_ok};
                rem_q <= sub_ok ? diff[XLEN-1:0] : shifted[XLEN-1:0];
            end
            default: ;
        endcase
    end

endmodule

/* logic/multiplier.sv */
`timescale 1ns/1ps

// iterative shift-add multiplier, MUL_STEP_BITS multiplier bits per cycle
module multiplier #(
    parameter int MUL_STEP_BITS = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  logic                 ready_i,
    input  muldiv_pkg::mul_op_e  op_i,
    input  muldiv_pkg::eng_req_t req_i,
    output logic                 busy_o,
    output muldiv_pkg::md_rsp_t  rsp_o
);
    import rv_core_pkg::*;
    import muldiv_pkg::*;

    localparam int STEPS = XLEN / MUL_STEP_BITS; // CALC cycles
    localparam int CNT_W = $clog2(STEPS);

    typedef enum logic [1:0] {
        IDLE,
        START,
        CALC,
        END
    } state_e;

    state_e             state_q;
    mul_op_e            op_q;
    logic [CNT_W-1:0]   cnt_q;
    logic               neg_q;    // product must be negated at the end
    word_t              a_q;
    word_t              b_q;
    logic [2*XLEN-1:0]  mcand_q;  // multiplicand, shifts left each step
    word_t              mplier_q; // multiplier, shifts right each step
    logic [2*XLEN-1:0]  prod_q;

    logic               a_neg;
    logic               b_neg;
    word_t              a_mag;
    word_t              b_mag;
    logic [2*XLEN-1:0]  step_sum;
    logic [2*XLEN-1:0]  prod_fix;

    // rs1 is signed for MULH and MULHSU, rs2 only for MULH
    assign a_neg = (op_q == MUL_HSS || op_q == MUL_HSU) && a_q[XLEN-1];
    assign b_neg = (op_q == MUL_HSS) && b_q[XLEN-1];
    assign a_mag = a_neg ? -a_q : a_q;
    assign b_mag = b_neg ? -b_q : b_q;

    // add the partial products of this step
    always_comb begin
        step_sum = prod_q;
        for (int j = 0; j < MUL_STEP_BITS; j++) begin
            if (mplier_q[j]) begin
                step_sum = step_sum + (mcand_q << j);
            end
        end
    end

    assign prod_fix = neg_q ? -prod_q : prod_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            op_q    <= MUL_LO;
            cnt_q   <= '0;
            neg_q   <= 1'b0;
            busy_o  <= 1'b0;
            rsp_o   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (ready_i) begin
                        rsp_o.valid <= 1'b0; // result taken
                        if (start_i) begin
                            op_q    <= op_i;
                            busy_o  <= 1'b1;
                            state_q <= START;
                        end else begin
                            rsp_o.result <= '0;
                        end
                    end
                end
                START: begin
                    neg_q   <= a_neg ^ b_neg;
                    cnt_q   <= CNT_W'(STEPS - 1);
                    state_q <= CALC;
                end
                CALC: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == '0) begin
                        state_q <= END;
                    end
                end
                END: begin
                    state_q     <= IDLE;
                    busy_o      <= 1'b0;
                    rsp_o.valid <= 1'b1;
                    if (op_q == MUL_LO) begin
                        rsp_o.result <= prod_fix[XLEN-1:0];
                    end else begin
                        rsp_o.result <= prod_fix[2*XLEN-1:XLEN];
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // operand and product datapath
    always_ff @(posedge clk) begin
        case (state_q)
            IDLE: begin
                if (ready_i && start_i) begin
                    a_q <= req_i.a;
                    b_q <= req_i.b;
                end
            end
            START: begin
                mcand_q  <= {{XLEN{1'b0}}, a_mag};
                mplier_q <= b_mag;
                prod_q   <= '0;
            end
            CALC: begin
                mcand_q  <= mcand_q << MUL_STEP_BITS;
                mplier_q <= mplier_q >> MUL_STEP_BITS;
                prod_q   <= step_sum;
            end
            default: ;
        endcase
    end

endmodule

/* logic/muldiv_dispatch.sv */
`timescale 1ns/1ps

module muldiv_dispatch (
    input  logic                 clk,
    input  logic                 rst_n,
    input  muldiv_pkg::md_req_t  req_i,
    input  logic                 start_i,
    input  logic                 mul_busy_i,
    input  logic                 div_busy_i,
    input  muldiv_pkg::md_rsp_t  mul_rsp_i,
    input  muldiv_pkg::md_rsp_t  div_rsp_i,
    output muldiv_pkg::eng_req_t eng_req_o,
    output logic                 mul_start_o,
    output muldiv_pkg::mul_op_e  mul_op_o,
    output logic                 div_start_o,
    output muldiv_pkg::div_op_e  div_op_o,
    output logic                 busy_o,
    output muldiv_pkg::md_rsp_t  rsp_o
);
    import muldiv_pkg::*;

    logic is_div;      // request belongs to the divider
    logic owner_div_q; // engine of the operation in flight

    assign is_div = req_i.op inside {MD_DIV, MD_DIVU, MD_REM, MD_REMU};

    // funct3 to engine opcode
    always_comb begin
        mul_op_o = MUL_LO;
        div_op_o = DIV_S;
        case (req_i.op)
            MD_MULH:   mul_op_o = MUL_HSS;
            MD_MULHSU: mul_op_o = MUL_HSU;
            MD_MULHU:  mul_op_o = MUL_HUU;
            MD_DIVU:   div_op_o = DIV_U;
            MD_REM:    div_op_o = REM_S;
            MD_REMU:   div_op_o = REM_U;
            default: ;
        endcase
    end

    assign eng_req_o.a = req_i.rs1;
    assign eng_req_o.b = req_i.rs2;

    assign mul_start_o = start_i & ~is_div;
    assign div_start_o = start_i & is_div;

    // remember who got the last start so the right result comes back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_div_q <= 1'b0;
        end else if (start_i && !busy_o) begin
            owner_div_q <= is_div;
        end
    end

    assign busy_o = mul_busy_i | div_busy_i;
    assign rsp_o  = owner_div_q ? div_rsp_i : mul_rsp_i;

endmodule

/* logic/muldiv_pkg.sv */
// RV32M operation codes and the request/response records of the mul/div unit
package muldiv_pkg;

    import rv_core_pkg::*;

    // funct3 encoding of the M extension
    typedef enum logic [2:0] {
        MD_MUL    = 3'b000,
        MD_MULH   = 3'b001,
        MD_MULHSU = 3'b010,
        MD_MULHU  = 3'b011,
        MD_DIV    = 3'b100,
        MD_DIVU   = 3'b101,
        MD_REM    = 3'b110,
        MD_REMU   = 3'b111
    } md_op_e;

    typedef enum logic [1:0] {
        MUL_LO  = 2'd0, // low word, sign does not matter
        MUL_HSS = 2'd1, // high word, signed x signed
        MUL_HSU = 2'd2, // high word, signed x unsigned
        MUL_HUU = 2'd3  // high word, unsigned x unsigned
    } mul_op_e;

    typedef enum logic [1:0] {
        DIV_S = 2'd0,
        DIV_U = 2'd1,
        REM_S = 2'd2,
        REM_U = 2'd3
    } div_op_e;

    // request from the execute stage
    typedef struct packed {
        md_op_e op;
        word_t  rs1;
        word_t  rs2;
    } md_req_t;

    // operands as latched by an engine
    typedef struct packed {
        word_t a;
        word_t b;
    } eng_req_t;

    typedef struct packed {
        logic  valid;
        word_t result;
    } md_rsp_t;

endpackage

/* logic/rv_core_pkg.sv */
// core-wide data width and word type
package rv_core_pkg;

    // RV32 datapath width
    localparam int unsigned XLEN = 32;

    // one architectural register value
    typedef logic [XLEN-1:0] word_t;

endpackage
